//--- rtl/csr_addr_pkg.sv
`default_nettype none

package csr_addr_pkg;

   // ==============================
   // data word and address word
   // ==============================
   localparam int xlen = 32;                   // rv32 data width

   typedef logic [xlen-1:0] csr_data_t;

   typedef union packed {
      logic [11:0] raw;                        // full csr number, used for matching
      struct packed {
         logic [1:0] access;                   // 2'b11 marks a read-only csr
         logic [1:0] priv;                     // lowest privilege allowed to touch it
         logic [7:0] index;
      } fld;
   } csr_addr_u;

   // bit 2 set for any access, low bits nonzero for a modifying command
   typedef enum logic [2:0] {
      cmd_idle  = 3'b000,
      cmd_read  = 3'b100,
      cmd_write = 3'b101,
      cmd_set   = 3'b110,
      cmd_clear = 3'b111
   } csr_cmd_e;

   typedef struct packed {
      logic        en;                         // legal modifying access this cycle
      logic [11:0] addr;
      csr_data_t   data;                       // already merged for set and clear
   } csr_write_t;

   // ==============================
   // address map
   // ==============================
   localparam logic [11:0] csr_mstatus   = 12'h300;
   localparam logic [11:0] csr_misa      = 12'h301;
   localparam logic [11:0] csr_mie       = 12'h304;
   localparam logic [11:0] csr_mtvec     = 12'h305;
   localparam logic [11:0] csr_mscratch  = 12'h340;
   localparam logic [11:0] csr_mepc      = 12'h341;
   localparam logic [11:0] csr_mcause    = 12'h342;
   localparam logic [11:0] csr_mtval     = 12'h343;
   localparam logic [11:0] csr_mip       = 12'h344;
   localparam logic [11:0] csr_mcycle    = 12'hb00;
   localparam logic [11:0] csr_minstret  = 12'hb02;
   localparam logic [11:0] csr_mcycleh   = 12'hb80;
   localparam logic [11:0] csr_minstreth = 12'hb82;
   localparam logic [11:0] csr_cycle     = 12'hc00;   // user read aliases
   localparam logic [11:0] csr_instret   = 12'hc02;
   localparam logic [11:0] csr_cycleh    = 12'hc80;
   localparam logic [11:0] csr_instreth  = 12'hc82;
   localparam logic [11:0] csr_mvendorid = 12'hf11;
   localparam logic [11:0] csr_marchid   = 12'hf12;
   localparam logic [11:0] csr_mimpid    = 12'hf13;
   localparam logic [11:0] csr_mhartid   = 12'hf14;

endpackage

`default_nettype wire

//--- rtl/csr_trap_pkg.sv
`default_nettype none

package csr_trap_pkg;

   // ==============================
   // privilege and cause codes
   // ==============================
   typedef enum logic [1:0] {
      prv_user    = 2'b00,
      prv_machine = 2'b11                      // no supervisor mode on this core
   } prv_e;

   localparam logic [3:0] cause_inst_misaligned = 4'd0;   // mtval takes the pc
   localparam logic [3:0] cause_breakpoint      = 4'd3;
   localparam logic [3:0] irq_software          = 4'd3;   // interrupt codes, mcause[31] set
   localparam logic [3:0] irq_timer             = 4'd7;
   localparam logic [3:0] irq_external          = 4'd11;

   // ==============================
   // register layouts
   // ==============================
   typedef struct packed {
      logic [18:0] zero_hi;                    // 31:13 read zero
      prv_e        mpp;                        // 12:11
      logic [2:0]  zero_8;
      logic        mpie;                       // 7
      logic [2:0]  zero_4;
      logic        mie;                        // 3, global machine interrupt enable
      logic [2:0]  zero_0;
   } mstatus_t;

   typedef struct packed {
      logic                    exception;
      logic [3:0]              exception_code;
      logic                    eret;           // mret in execute
      logic                    retire;         // one instruction retires
      csr_addr_pkg::csr_data_t pc;
      csr_addr_pkg::csr_data_t bad_addr;
   } trap_req_t;

   typedef struct packed {
      csr_addr_pkg::csr_data_t mtvec;
      csr_addr_pkg::csr_data_t mscratch;
      csr_addr_pkg::csr_data_t mie;
      csr_addr_pkg::csr_data_t mip;
   } machine_regs_t;

   typedef struct packed {
      prv_e                    prv;
      mstatus_t                mstatus;
      csr_addr_pkg::csr_data_t mepc;
      csr_addr_pkg::csr_data_t mcause;
      csr_addr_pkg::csr_data_t mtval;
   } trap_state_t;

endpackage

`default_nettype wire

//--- rtl/csr_access_decode.sv
`timescale 1ns/100ps
`default_nettype none

module csr_access_decode (
   input  csr_addr_pkg::csr_addr_u  addr,
   input  csr_addr_pkg::csr_cmd_e   cmd,
   input  csr_addr_pkg::csr_data_t  wdata,
   input  csr_addr_pkg::csr_data_t  rdata,          // current value, for set and clear
   input  logic                     defined,
   input  csr_trap_pkg::prv_e       prv,
   output csr_addr_pkg::csr_write_t csr_wr,
   output logic                     illegal_access
);

   logic                    access_en;
   logic                    modify;
   logic                    ro_write;
   logic                    prv_fault;
   csr_addr_pkg::csr_data_t wr_data;

   // ==============================
   // command decode and legality
   // ==============================
   assign access_en = cmd[2];                       // any command but idle
   assign modify    = |cmd[1:0];                    // write, set or clear

   assign ro_write  = modify && (addr.fld.access == 2'b11);
   assign prv_fault = access_en && (addr.fld.priv > prv);   // csr above current mode

   assign illegal_access = ro_write || prv_fault || (access_en && !defined);

   // ==============================
   // write data merge
   // ==============================
   always_comb begin
      case (cmd)
         csr_addr_pkg::cmd_set:   wr_data = rdata | wdata;    // set bits
         csr_addr_pkg::cmd_clear: wr_data = rdata & ~wdata;   // clear bits
         default:                 wr_data = wdata;            // plain write
      endcase
   end

   // an illegal access never reaches a register
   assign csr_wr = '{
      en:   modify && !illegal_access,
      addr: addr.raw,
      data: wr_data
   };

endmodule

`default_nettype wire

//--- rtl/csr_read_mux.sv
`timescale 1ns/100ps
`default_nettype none

module csr_read_mux #(
   parameter csr_addr_pkg::csr_data_t hart_id = '0
) (
   input  csr_addr_pkg::csr_addr_u     addr,
   input  csr_trap_pkg::machine_regs_t mregs,
   input  csr_trap_pkg::trap_state_t   tstate,
   input  logic [63:0]                 cycle_count,
   input  logic [63:0]                 instret_count,
   output csr_addr_pkg::csr_data_t     rdata,
   output logic                        defined
);

   // ==============================
   // identity words
   // ==============================
   localparam csr_addr_pkg::csr_data_t misa_val      = 32'h4010_0100; // mxl=1, i and u
   localparam csr_addr_pkg::csr_data_t mvendorid_val = 32'h0000_0000; // non-commercial
   localparam csr_addr_pkg::csr_data_t marchid_val   = 32'h8000_0001;
   localparam csr_addr_pkg::csr_data_t mimpid_val    = 32'h0000_8000; // first version

   // ==============================
   // address decode
   // ==============================
   always_comb begin
      defined = 1'b1;                              // cleared only by the default arm
      case (addr.raw)
         csr_addr_pkg::csr_mstatus:   rdata = tstate.mstatus;
         csr_addr_pkg::csr_misa:      rdata = misa_val;
         csr_addr_pkg::csr_mie:       rdata = mregs.mie;
         csr_addr_pkg::csr_mtvec:     rdata = mregs.mtvec;
         csr_addr_pkg::csr_mscratch:  rdata = mregs.mscratch;
         csr_addr_pkg::csr_mepc:      rdata = tstate.mepc;
         csr_addr_pkg::csr_mcause:    rdata = tstate.mcause;
         csr_addr_pkg::csr_mtval:     rdata = tstate.mtval;
         csr_addr_pkg::csr_mip:       rdata = mregs.mip;
         csr_addr_pkg::csr_mcycle,
         csr_addr_pkg::csr_cycle:     rdata = cycle_count[31:0];
         csr_addr_pkg::csr_mcycleh,
         csr_addr_pkg::csr_cycleh:    rdata = cycle_count[63:32];    // high half
         csr_addr_pkg::csr_minstret,
         csr_addr_pkg::csr_instret:   rdata = instret_count[31:0];
         csr_addr_pkg::csr_minstreth,
         csr_addr_pkg::csr_instreth:  rdata = instret_count[63:32];
         csr_addr_pkg::csr_mvendorid: rdata = mvendorid_val;
         csr_addr_pkg::csr_marchid:   rdata = marchid_val;
         csr_addr_pkg::csr_mimpid:    rdata = mimpid_val;
         csr_addr_pkg::csr_mhartid:   rdata = hart_id;
         default: begin
            rdata   = '0;                          // unknown csr reads zero
            defined = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- rtl/csr_machine_regs.sv
`timescale 1ns/100ps
`default_nettype none

module csr_machine_regs #(
   parameter csr_addr_pkg::csr_data_t reset_vector = 32'h8000_0000
) (
   input  logic                        clk,
   input  logic                        reset,
   input  csr_addr_pkg::csr_write_t    csr_wr,
   input  logic                        ext_irq,
   input  logic                        timer_irq,
   output csr_trap_pkg::machine_regs_t mregs
);

   csr_addr_pkg::csr_data_t mtvec;
   csr_addr_pkg::csr_data_t mscratch;
   csr_addr_pkg::csr_data_t mie;
   logic                    msip;                  // only software-writable mip bit

   // ==============================
   // control registers
   // ==============================
   always_ff @(posedge clk) begin
      if (reset) begin
         mtvec <= {reset_vector[31:2], 2'b00};
         mie   <= '0;
         msip  <= 1'b0;
      end else if (csr_wr.en) begin
         case (csr_wr.addr)
            csr_addr_pkg::csr_mtvec: mtvec <= {csr_wr.data[31:2], 2'b00}; // direct mode only
            csr_addr_pkg::csr_mie:   mie   <= csr_wr.data;
            csr_addr_pkg::csr_mip:   msip  <= csr_wr.data[3];
            default: ;
         endcase
      end
   end

   // scratch word for the trap handler
   always_ff @(posedge clk) begin
      if (reset) begin
         mscratch <= '0;
      end else if (csr_wr.en && (csr_wr.addr == csr_addr_pkg::csr_mscratch)) begin
         mscratch <= csr_wr.data;
      end
   end

   // mip bits are external 11, timer 7 and software 3
   assign mregs = '{
      mtvec:    mtvec,
      mscratch: mscratch,
      mie:      mie,
      mip:      {20'b0, ext_irq, 3'b0, timer_irq, 3'b0, msip, 3'b0}
   };

endmodule

`default_nettype wire

//--- rtl/csr_counters.sv
`timescale 1ns/100ps
`default_nettype none

module csr_counters (
   input  logic                     clk,
   input  logic                     reset,
   input  csr_addr_pkg::csr_write_t csr_wr,
   input  logic                     retire,
   output logic [63:0]              cycle_count,
   output logic [63:0]              instret_count
);

   // next counter value; a write to either half holds the count for that cycle
   function automatic logic [63:0] next_count(
      input logic [63:0]              cur,
      input logic                     inc,
      input csr_addr_pkg::csr_write_t wr,
      input logic [11:0]              lo_addr,
      input logic [11:0]              hi_addr
   );
      logic [63:0] nxt;
      nxt = cur;
      if (wr.en && (wr.addr == lo_addr)) begin
         nxt[31:0] = wr.data;                      // low half write
      end else if (wr.en && (wr.addr == hi_addr)) begin
         nxt[63:32] = wr.data;                     // high half write
      end else if (inc) begin
         nxt = cur + 64'd1;
      end
      return nxt;
   endfunction

   // ==============================
   // cycle and instret
   // ==============================
   always_ff @(posedge clk) begin
      if (reset) begin
         cycle_count   <= '0;
         instret_count <= '0;
      end else begin
         cycle_count   <= next_count(cycle_count, 1'b1, csr_wr,
                                     csr_addr_pkg::csr_mcycle, csr_addr_pkg::csr_mcycleh);
         instret_count <= next_count(instret_count, retire, csr_wr,
                                     csr_addr_pkg::csr_minstret, csr_addr_pkg::csr_minstreth);
      end
   end

endmodule

`default_nettype wire

//--- rtl/csr_trap_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module csr_trap_ctrl (
   input  logic                        clk,
   input  logic                        reset,
   input  csr_addr_pkg::csr_write_t    csr_wr,
   input  csr_trap_pkg::trap_req_t     trap,
   input  csr_trap_pkg::machine_regs_t mregs,
   output csr_trap_pkg::trap_state_t   tstate,
   output logic                        interrupt_pending,
   output logic                        interrupt_taken,
   output csr_addr_pkg::csr_data_t     handler_pc,
   output csr_addr_pkg::csr_data_t     epc
);

   csr_trap_pkg::prv_e      prv;
   csr_trap_pkg::mstatus_t  mstatus;
   csr_trap_pkg::mstatus_t  mstatus_wr;             // legalized write value
   csr_addr_pkg::csr_data_t mepc;
   csr_addr_pkg::csr_data_t mcause;
   csr_addr_pkg::csr_data_t mtval;
   csr_addr_pkg::csr_data_t irq_active;
   csr_addr_pkg::csr_data_t pc_aligned;
   logic [3:0]              irq_code;
   logic                    trap_entry;
   logic                    exc_taken;

   // ==============================
   // interrupt selection
   // ==============================
   assign irq_active        = mregs.mie & mregs.mip;
   assign interrupt_pending = |mregs.mip;           // pending, maybe masked
   assign interrupt_taken   = |irq_active &&
                              ((prv == csr_trap_pkg::prv_user) || mstatus.mie);

   always_comb begin
      if (irq_active[11])     irq_code = csr_trap_pkg::irq_external;  // highest first
      else if (irq_active[7]) irq_code = csr_trap_pkg::irq_timer;
      else                    irq_code = csr_trap_pkg::irq_software;
   end

   assign exc_taken  = trap.exception && !interrupt_taken;   // interrupt wins
   assign trap_entry = interrupt_taken || trap.exception;
   assign pc_aligned = {trap.pc[31:2], 2'b00};

   always_comb begin
      mstatus_wr      = '0;
      mstatus_wr.mie  = csr_wr.data[3];
      mstatus_wr.mpie = csr_wr.data[7];
      mstatus_wr.mpp  = (csr_wr.data[12:11] == 2'b11) ? csr_trap_pkg::prv_machine
                                                      : csr_trap_pkg::prv_user; // warl
   end

   // ==============================
   // privilege and mstatus stack
   // ==============================
   always_ff @(posedge clk) begin
      if (reset) begin
         prv     <= csr_trap_pkg::prv_machine;
         mstatus <= '0;
      end else begin
         if (trap_entry) begin
            prv          <= csr_trap_pkg::prv_machine;
            mstatus.mpie <= mstatus.mie;
            mstatus.mie  <= 1'b0;                  // handler starts masked
            mstatus.mpp  <= prv;
         end else if (trap.eret) begin
            prv          <= mstatus.mpp;
            mstatus.mie  <= mstatus.mpie;
            mstatus.mpie <= 1'b1;
            mstatus.mpp  <= csr_trap_pkg::prv_user;
         end
         if (csr_wr.en && (csr_wr.addr == csr_addr_pkg::csr_mstatus)) begin
            mstatus <= mstatus_wr;                 // later assignment beats the trap update
         end
      end
   end

   // ==============================
   // mepc, mcause, mtval
   // ==============================
   always_ff @(posedge clk) begin
      if (reset) begin
         mepc   <= '0;
         mcause <= '0;
         mtval  <= '0;
      end else begin
         if (csr_wr.en && (csr_wr.addr == csr_addr_pkg::csr_mepc))
            mepc <= {csr_wr.data[31:2], 2'b00};
         else if (interrupt_taken)
            mepc <= pc_aligned + 32'd4;            // resume after the interrupted instr
         else if (exc_taken)
            mepc <= pc_aligned;                    // faulting instr

         if (csr_wr.en && (csr_wr.addr == csr_addr_pkg::csr_mcause))
            mcause <= {csr_wr.data[31], 27'b0, csr_wr.data[3:0]};
         else if (interrupt_taken)
            mcause <= {1'b1, 27'b0, irq_code};
         else if (exc_taken)
            mcause <= {1'b0, 27'b0, trap.exception_code};

         if (csr_wr.en && (csr_wr.addr == csr_addr_pkg::csr_mtval))
            mtval <= csr_wr.data;
         else if (exc_taken)
            mtval <= (trap.exception_code == csr_trap_pkg::cause_inst_misaligned) ?
                     trap.pc : trap.bad_addr;
      end
   end

   assign handler_pc = mregs.mtvec;                 // single direct-mode handler
   assign epc        = mepc;

   assign tstate = '{prv: prv, mstatus: mstatus, mepc: mepc, mcause: mcause, mtval: mtval};

endmodule

`default_nettype wire

//--- rtl/csr_file_top.sv
`timescale 1ns/100ps
`default_nettype none

module csr_file_top #(
   parameter csr_addr_pkg::csr_data_t hart_id      = '0,
   parameter csr_addr_pkg::csr_data_t reset_vector = 32'h8000_0000
) (
   input  logic                     clk,
   input  logic                     reset,
   input  csr_addr_pkg::csr_addr_u  addr,
   input  csr_addr_pkg::csr_cmd_e   cmd,
   input  csr_addr_pkg::csr_data_t  wdata,
   input  logic                     ext_irq,
   input  logic                     timer_irq,
   input  csr_trap_pkg::trap_req_t  trap,
   output csr_addr_pkg::csr_data_t  rdata,
   output logic                     illegal_access,
   output csr_trap_pkg::prv_e       prv,
   output logic                     interrupt_pending,
   output logic                     interrupt_taken,
   output csr_addr_pkg::csr_data_t  handler_pc,
   output csr_addr_pkg::csr_data_t  epc
);

   csr_addr_pkg::csr_write_t    csr_wr;            // shared write port
   csr_trap_pkg::machine_regs_t mregs;
   csr_trap_pkg::trap_state_t   tstate;
   logic                        defined;
   logic [63:0]                 cycle_count;
   logic [63:0]                 instret_count;

   // ==============================
   // core port
   // ==============================
   csr_access_decode u_decode (
      .addr, .cmd, .wdata, .rdata, .defined, .prv, .csr_wr, .illegal_access
   );

   csr_read_mux #(.hart_id(hart_id)) u_read_mux (
      .addr, .mregs, .tstate, .cycle_count, .instret_count, .rdata, .defined
   );

   // ==============================
   // register holders
   // ==============================
   csr_machine_regs #(.reset_vector(reset_vector)) u_machine_regs (
      .clk, .reset, .csr_wr, .ext_irq, .timer_irq, .mregs
   );

   csr_counters u_counters (
      .clk, .reset, .csr_wr, .retire(trap.retire), .cycle_count, .instret_count
   );

   csr_trap_ctrl u_trap_ctrl (
      .clk, .reset, .csr_wr, .trap, .mregs, .tstate,
      .interrupt_pending, .interrupt_taken, .handler_pc, .epc
   );

   assign prv = tstate.prv;                        // current mode out to the pipeline

endmodule

`default_nettype wire

//--- dv/csr_file_model.svh
`ifndef CSR_FILE_MODEL_SVH
`define CSR_FILE_MODEL_SVH

// ==============================
// shadow state of the csr file
// ==============================
logic [1:0]  m_prv;
logic        m_mstatus_mie;                     // mstatus.mie
logic        m_mpie;
logic [1:0]  m_mpp;
logic [31:0] m_mtvec, m_mscratch, m_mie, m_mepc, m_mcause, m_mtval;
logic        m_msip;
logic [63:0] m_cycle, m_instret;

task automatic model_reset();
   m_prv = 2'b11;                               // machine mode out of reset
   {m_mstatus_mie, m_mpie, m_mpp} = '0;
   m_mtvec = {reset_vector[31:2], 2'b00};
   {m_mscratch, m_mie, m_mepc, m_mcause, m_mtval} = '0;
   m_msip = 1'b0;
   m_cycle = '0;
   m_instret = '0;
endtask

function automatic logic [31:0] model_mstatus();
   return {19'b0, m_mpp, 3'b0, m_mpie, 3'b0, m_mstatus_mie, 3'b0};
endfunction

function automatic logic [31:0] model_mip();
   return {20'b0, ext_irq, 3'b0, timer_irq, 3'b0, m_msip, 3'b0};   // live irq lines
endfunction

function automatic logic model_irq_taken();
   return (|(m_mie & model_mip())) && ((m_prv == 2'b00) || m_mstatus_mie);
endfunction

// {defined, read value} for one csr number
function automatic logic [32:0] model_lookup(input logic [11:0] a);
   case (a)
      12'h300: return {1'b1, model_mstatus()};
      12'h301: return {1'b1, 32'h4010_0100};    // rv32, i and u
      12'h304: return {1'b1, m_mie};
      12'h305: return {1'b1, m_mtvec};
      12'h340: return {1'b1, m_mscratch};
      12'h341: return {1'b1, m_mepc};
      12'h342: return {1'b1, m_mcause};
      12'h343: return {1'b1, m_mtval};
      12'h344: return {1'b1, model_mip()};
      12'hb00, 12'hc00: return {1'b1, m_cycle[31:0]};
      12'hb80, 12'hc80: return {1'b1, m_cycle[63:32]};
      12'hb02, 12'hc02: return {1'b1, m_instret[31:0]};
      12'hb82, 12'hc82: return {1'b1, m_instret[63:32]};
      12'hf11: return {1'b1, 32'h0};
      12'hf12: return {1'b1, 32'h8000_0001};
      12'hf13: return {1'b1, 32'h0000_8000};
      12'hf14: return {1'b1, hart_id};
      default: return {1'b0, 32'h0};            // undefined, reads zero
   endcase
endfunction

function automatic logic model_illegal(input logic [11:0] a, input csr_addr_pkg::csr_cmd_e c);
   logic [32:0] lk;
   logic        any;
   logic        modify;
   lk = model_lookup(a);
   any = (c != csr_addr_pkg::cmd_idle);
   modify = any && (c != csr_addr_pkg::cmd_read);
   return (modify && (a[11:10] == 2'b11)) || (any && (a[9:8] > m_prv)) || (any && !lk[32]);
endfunction

// one clock edge of the csr file
task automatic model_step(input logic [11:0] a, input csr_addr_pkg::csr_cmd_e c,
                          input logic [31:0] d, input logic exc, input logic [3:0] code,
                          input logic er, input logic ret, input logic [31:0] pc,
                          input logic [31:0] bad);
   logic [32:0] lk;
   logic [31:0] wd;
   logic [31:0] act;
   logic [31:0] pca;
   logic        irq;
   logic        wen;
   logic [3:0]  icode;
   lk = model_lookup(a);
   irq = model_irq_taken();
   act = m_mie & model_mip();
   icode = act[11] ? 4'd11 : (act[7] ? 4'd7 : 4'd3);   // external, timer, software
   case (c)
      csr_addr_pkg::cmd_set:   wd = lk[31:0] | d;
      csr_addr_pkg::cmd_clear: wd = lk[31:0] & ~d;
      default:                 wd = d;
   endcase
   wen = (c != csr_addr_pkg::cmd_idle) && (c != csr_addr_pkg::cmd_read) && !model_illegal(a, c);
   pca = {pc[31:2], 2'b00};
   if (irq || exc) begin                        // trap entry
      m_mpie = m_mstatus_mie;
      m_mstatus_mie = 1'b0;
      m_mpp = m_prv;
      m_prv = 2'b11;
   end else if (er) begin                       // mret
      m_prv = m_mpp;
      m_mstatus_mie = m_mpie;
      m_mpie = 1'b1;
      m_mpp = 2'b00;
   end
   if (irq) begin
      m_mepc = pca + 32'd4;
      m_mcause = {1'b1, 27'b0, icode};
   end else if (exc) begin
      m_mepc = pca;
      m_mcause = {28'b0, code};
      m_mtval = (code == 4'd0) ? pc : bad;
   end
   if (wen) begin                               // csr write wins over the trap
      case (a)
         12'h300: begin
            m_mstatus_mie = wd[3];
            m_mpie = wd[7];
            m_mpp = (wd[12:11] == 2'b11) ? 2'b11 : 2'b00;
         end
         12'h304: m_mie = wd;
         12'h305: m_mtvec = wd & ~32'h3;
         12'h340: m_mscratch = wd;
         12'h341: m_mepc = wd & ~32'h3;
         12'h342: m_mcause = {wd[31], 27'b0, wd[3:0]};
         12'h343: m_mtval = wd;
         12'h344: m_msip = wd[3];
         default: ;
      endcase
   end
   if (wen && (a == 12'hb00)) m_cycle[31:0] = wd;
   else if (wen && (a == 12'hb80)) m_cycle[63:32] = wd;
   else m_cycle = m_cycle + 64'd1;
   if (wen && (a == 12'hb02)) m_instret[31:0] = wd;
   else if (wen && (a == 12'hb82)) m_instret[63:32] = wd;
   else if (ret) m_instret = m_instret + 64'd1;
endtask

`endif

//--- dv/csr_file_tb.sv
`timescale 1ns/100ps
`default_nettype none

module csr_file_tb;

   localparam logic [31:0] hart_id      = 32'h0000_0005;
   localparam logic [31:0] reset_vector = 32'h8000_0100;

   logic clk, reset, ext_irq, timer_irq;
   csr_addr_pkg::csr_addr_u     addr;
   csr_addr_pkg::csr_cmd_e      cmd;
   csr_addr_pkg::csr_data_t     wdata, rdata, handler_pc, epc;
   csr_trap_pkg::trap_req_t     trap;
   csr_trap_pkg::prv_e          prv;
   logic illegal_access, interrupt_pending, interrupt_taken;

   logic        chk_en, exp_illegal, exp_taken, exp_pending, last_taken;
   logic [31:0] exp_rdata, exp_handler, exp_epc, exp_prv;
   int          n_checks, n_errors, n_tests, test_start;
   csr_addr_pkg::csr_cmd_e cmds[3] = '{csr_addr_pkg::cmd_write, csr_addr_pkg::cmd_set,
                                       csr_addr_pkg::cmd_clear};
   logic [11:0] rw_regs[4] = '{12'h340, 12'h305, 12'h304, 12'h341};
   logic [11:0] model_ids[7] = '{12'h305, 12'h300, 12'h301, 12'hf11, 12'hf12, 12'hf13, 12'hf14};
   logic [11:0] trap_ids[4]  = '{12'h342, 12'h341, 12'h343, 12'h300};
   logic [11:0] cnt_ids[8]   = '{12'hb00, 12'hc00, 12'hb80, 12'hc80,
                                 12'hb02, 12'hc02, 12'hb82, 12'hc82};

   `include "csr_file_model.svh"

   csr_file_top #(.hart_id(hart_id), .reset_vector(reset_vector)) csr_file_top_inst (
      .clk, .reset, .addr, .cmd, .wdata, .ext_irq, .timer_irq, .trap,
      .rdata, .illegal_access, .prv, .interrupt_pending, .interrupt_taken, .handler_pc, .epc
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                    // 4 ns period
   end

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   // ==============================
   // compare just before each edge
   // ==============================
   initial begin
      forever begin
         @(posedge clk);
         #3;
         if (chk_en) begin
            check_value("rdata", rdata, exp_rdata);
            check_value("illegal_access", 32'(illegal_access), 32'(exp_illegal));
            check_value("prv", 32'(prv), exp_prv);
            check_value("handler_pc", handler_pc, exp_handler);
            check_value("epc", epc, exp_epc);
            check_value("interrupt_taken", 32'(interrupt_taken), 32'(exp_taken));
            check_value("interrupt_pending", 32'(interrupt_pending), 32'(exp_pending));
         end
      end
   end

   // drives one cycle at edge+1 and returns at the next edge+1
   task automatic step(input logic [11:0] a, input csr_addr_pkg::csr_cmd_e c,
                       input logic [31:0] d, input logic exc, input logic [3:0] code,
                       input logic er, input logic ret, input logic [31:0] pc,
                       input logic [31:0] bad);
      logic [32:0] lk;
      addr.raw = a;
      cmd = c;
      wdata = d;
      trap = '{exception: exc, exception_code: code, eret: er, retire: ret, pc: pc, bad_addr: bad};
      lk = model_lookup(a);
      exp_rdata = lk[31:0];
      exp_illegal = model_illegal(a, c);
      exp_prv = {30'b0, m_prv};                 // state before this edge
      exp_handler = m_mtvec;
      exp_epc = m_mepc;
      exp_taken = model_irq_taken();
      exp_pending = |model_mip();
      chk_en = 1'b1;
      model_step(a, c, d, exc, code, er, ret, pc, bad);
      #1 last_taken = interrupt_taken;
      @(posedge clk);
      #1;
   endtask

   task automatic csr_access(input logic [11:0] a, input csr_addr_pkg::csr_cmd_e c,
                             input logic [31:0] d);
      step(a, c, d, 1'b0, 4'd0, 1'b0, 1'b0, 32'h0, 32'h0);
   endtask

   task automatic idle(input logic ret);
      step(12'h300, csr_addr_pkg::cmd_idle, 32'h0, 1'b0, 4'd0, 1'b0, ret, 32'h0000_2006, 32'h0);
   endtask

   task automatic finish_test(input string name);
      n_tests++;
      $display("test %0d %s: %0d errors", n_tests, name, n_errors - test_start);
      test_start = n_errors;
   endtask

   initial begin
      logic [31:0] pc;
      int          n;
      void'($urandom(96660));
      {n_checks, n_errors, n_tests, test_start} = '0;
      {chk_en, last_taken, ext_irq, timer_irq} = '0;
      addr = '0;
      cmd = csr_addr_pkg::cmd_idle;
      wdata = '0;
      trap = '0;
      reset = 1'b1;
      repeat (3) @(posedge clk);
      #1 reset = 1'b0;
      model_reset();

      foreach (model_ids[i]) csr_access(model_ids[i], csr_addr_pkg::cmd_read, 32'h0);
      finish_test("reset values");

      for (int i = 0; i < 16; i++) begin
         n = $urandom % 4;
         csr_access(rw_regs[n], cmds[$urandom % 3], $urandom);
         csr_access(rw_regs[n], csr_addr_pkg::cmd_read, 32'h0);
      end
      finish_test("read write set clear");

      csr_access(12'hf11, csr_addr_pkg::cmd_write, 32'hdead_beef);   // read-only
      csr_access(12'hf11, csr_addr_pkg::cmd_read, 32'h0);
      csr_access(12'h7c0, csr_addr_pkg::cmd_write, 32'h1);           // undefined
      csr_access(12'h7c0, csr_addr_pkg::cmd_read, 32'h0);
      csr_access(12'h300, csr_addr_pkg::cmd_write, 32'h0);           // mpp user
      step(12'h300, csr_addr_pkg::cmd_idle, 32'h0, 1'b0, 4'd0, 1'b1, 1'b0, 32'h0, 32'h0);
      csr_access(12'h340, csr_addr_pkg::cmd_write, 32'h1234_5678);   // now in user mode
      csr_access(12'h300, csr_addr_pkg::cmd_read, 32'h0);
      csr_access(12'hc00, csr_addr_pkg::cmd_read, 32'h0);            // user alias is legal
      step(12'h300, csr_addr_pkg::cmd_idle, 32'h0, 1'b1, 4'd3, 1'b0, 1'b0, 32'h400, 32'h0);
      csr_access(12'h340, csr_addr_pkg::cmd_read, 32'h0);
      finish_test("illegal access");

      csr_access(12'h305, csr_addr_pkg::cmd_write, $urandom);
      pc = $urandom | 32'h1;                    // misaligned fetch
      step(12'h300, csr_addr_pkg::cmd_idle, 32'h0, 1'b1, 4'd0, 1'b0, 1'b0, pc, $urandom);
      foreach (trap_ids[i]) csr_access(trap_ids[i], csr_addr_pkg::cmd_read, 32'h0);
      csr_access(12'h300, csr_addr_pkg::cmd_write, 32'h8);           // mie on
      step(12'h300, csr_addr_pkg::cmd_idle, 32'h0, 1'b1, 4'd3, 1'b0, 1'b0, $urandom, $urandom);
      foreach (trap_ids[i]) csr_access(trap_ids[i], csr_addr_pkg::cmd_read, 32'h0);
      step(12'h300, csr_addr_pkg::cmd_idle, 32'h0, 1'b0, 4'd0, 1'b1, 1'b0, 32'h0, 32'h0);
      csr_access(12'h300, csr_addr_pkg::cmd_read, 32'h0);
      finish_test("trap entry and mret");

      csr_access(12'h300, csr_addr_pkg::cmd_write, 32'h0);
      csr_access(12'h304, csr_addr_pkg::cmd_write, 32'h0000_0880);   // timer and external
      timer_irq = 1'b1;
      idle(1'b0);
      ext_irq = 1'b1;
      idle(1'b0);
      csr_access(12'h300, csr_addr_pkg::cmd_write, 32'h8);
      last_taken = 1'b0;
      for (n = 0; (n < 8) && !last_taken; n++) idle(1'b0);
      if (!last_taken) begin
         n_errors++;
         $display("timeout: interrupt_taken never went high");
      end
      csr_access(12'h342, csr_addr_pkg::cmd_read, 32'h0);
      csr_access(12'h341, csr_addr_pkg::cmd_read, 32'h0);
      {timer_irq, ext_irq} = 2'b00;
      idle(1'b0);
      finish_test("interrupt entry");

      csr_access(12'hb00, csr_addr_pkg::cmd_write, $urandom);
      repeat (5) idle(1'b0);
      foreach (cnt_ids[i]) csr_access(cnt_ids[i], csr_addr_pkg::cmd_read, 32'h0);
      csr_access(12'hb82, csr_addr_pkg::cmd_write, $urandom);
      repeat (12) idle(1'($urandom % 2));       // retire on random cycles
      foreach (cnt_ids[i]) csr_access(cnt_ids[i], csr_addr_pkg::cmd_read, 32'h0);
      finish_test("counters");

      chk_en = 1'b0;
      $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- csr_file.f
rtl/csr_addr_pkg.sv
rtl/csr_trap_pkg.sv
rtl/csr_access_decode.sv
rtl/csr_read_mux.sv
rtl/csr_machine_regs.sv
rtl/csr_counters.sv
rtl/csr_trap_ctrl.sv
rtl/csr_file_top.sv
+incdir+dv
dv/csr_file_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the csr file testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f csr_file.f --top-module csr_file_tb -Mdir obj_dir
./obj_dir/Vcsr_file_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
   echo "simulation ok"
   exit 0
else
   echo "simulation reported errors"
   exit 1
fi
